//--- hdl/psgBusArb.sv
`timescale 1ns/1ps

module psgBusArb #(
	parameter int NumChannels = 4
) (
	input logic clk,
	input logic rst,
	psgFetchIf.arb fetch [NumChannels],
	input logic busAck,
	output logic [psgCfgPkg::ChanIdxWidth-1:0] owner,
	output logic busy
);

	logic [psgCfgPkg::MaxChannels-1:0] reqAll;
	logic [psgCfgPkg::ChanIdxWidth-1:0] pick;
	logic granted;

	// unused request slots read as idle
	for (genvar i = 0; i < psgCfgPkg::MaxChannels; i++) begin : genReq
		if (i < NumChannels) begin : genUsed
			assign reqAll[i] = fetch[i].req;
			assign fetch[i].grant = granted && (owner == i);
		end else begin : genIdle
			assign reqAll[i] = 1'b0;
		end
	end

	// lowest numbered requester wins
	always_comb begin
		pick = '0;
		for (int i = psgCfgPkg::MaxChannels - 1; i >= 0; i--) begin
			if (reqAll[i])
				pick = i[psgCfgPkg::ChanIdxWidth-1:0];
		end
	end

	// owner keeps its last value while the bus sits idle
	always_ff @(posedge clk) begin
		if (rst) begin
			granted <= 1'b0;
			owner <= '0;
		end else if (!granted) begin
			if (|reqAll) begin
				granted <= 1'b1;
				owner <= pick;
			end
		end else if (busAck) begin
			granted <= 1'b0;
		end
	end

	assign busy = granted;

endmodule

//--- hdl/psgCfgPkg.sv
package psgCfgPkg;

	// ========================================
	// data sizes of the sample-fetch path
	// ========================================

	localparam int SampleWidth = 8;
	localparam int AddrWidth = 10;
	localparam int PhaseWidth = 16;
	localparam int VolWidth = 4;
	localparam int OutWidth = 16;

	// channel numbering, arbiter index is 3 bits wide
	localparam int MaxChannels = 8;
	localparam int ChanIdxWidth = 3;

	typedef logic signed [SampleWidth-1:0] sampleT;
	typedef logic [AddrWidth-1:0] memAddrT;
	typedef logic [PhaseWidth-1:0] phaseT;
	typedef logic [VolWidth-1:0] volT;
	typedef logic signed [OutWidth-1:0] outSampleT;

endpackage

//--- hdl/psgFetchIf.sv
`timescale 1ns/1ps

// one channel's read link into the shared sample memory
interface psgFetchIf;

	logic req;
	psgCfgPkg::memAddrT addr;
	logic grant;
	psgCfgPkg::sampleT data;
	logic ack;

	// channel holds req and addr until it sees ack
	modport chan (output req, output addr, input grant, input data, input ack);

	modport arb (input req, output grant);

	// ack is a single-cycle pulse, data valid with it
	modport mem (input addr, output data, output ack);

endinterface

//--- hdl/psgFrameMixer.sv
`timescale 1ns/1ps

module psgFrameMixer #(
	parameter int NumChannels = 4
) (
	input logic clk,
	input logic rst,
	input logic tickValid,
	output logic tickReady,
	output logic frameStart,
	input logic [NumChannels-1:0] done,
	input psgCfgPkg::sampleT sample [NumChannels],
	input psgCfgPkg::volT volume [NumChannels],
	output logic outValid,
	input logic outReady,
	output psgCfgPkg::outSampleT outSample
);

	// signed sample times unsigned volume, plus a sign bit for the volume
	localparam int ProdWidth = psgCfgPkg::SampleWidth + psgCfgPkg::VolWidth + 1;

	typedef enum logic [2:0] {stIdle, stWait, stScale, stSum, stPresent} stateT;

	stateT state;
	logic signed [ProdWidth-1:0] prod [NumChannels];
	psgCfgPkg::outSampleT acc;

	// ========================================
	// frame FSM
	// ========================================

	always_ff @(posedge clk) begin
		if (rst) begin
			state <= stIdle;
			frameStart <= 1'b0;
		end else begin
			frameStart <= 1'b0;
			case (state)
				stIdle: begin
					if (tickValid) begin
						frameStart <= 1'b1;
						state <= stWait;
					end
				end
				// done bits are stale while frameStart is still high
				stWait: if (!frameStart && &done) state <= stScale;
				stScale: state <= stSum;
				stSum: state <= stPresent;
				stPresent: if (outReady) state <= stIdle;
				default: state <= stIdle;
			endcase
		end
	end

	always_comb begin
		acc = '0;
		for (int i = 0; i < NumChannels; i++)
			acc = acc + prod[i];
	end

	// datapath, held steady outside the scale and sum cycles
	always_ff @(posedge clk) begin
		if (state == stScale) begin
			for (int i = 0; i < NumChannels; i++)
				prod[i] <= sample[i] * $signed({1'b0, volume[i]});
		end
		if (state == stSum)
			outSample <= acc;
	end

	assign tickReady = (state == stIdle);
	assign outValid = (state == stPresent);

endmodule

//--- hdl/psgRegPkg.sv
package psgRegPkg;

	// ========================================
	// host view of one channel's registers
	// ========================================

	localparam int RegDataWidth = 16;

	// wave index is the top LenWidth bits of the phase
	localparam int LenWidth = 8;

	// enable flag position in the control word, volume sits below it
	localparam int EnableBit = 4;

	typedef enum logic [1:0] {
		fieldIncr = 2'd0,
		fieldBase = 2'd1,
		fieldLen = 2'd2,
		fieldCtrl = 2'd3
	} regFieldE;

	typedef struct packed {
		psgCfgPkg::phaseT incr;
		psgCfgPkg::memAddrT base;
		logic [LenWidth-1:0] lenMask;
		psgCfgPkg::volT volume;
		logic enable;
	} chanRegsT;

endpackage

//--- hdl/psgWaveChannel.sv
`timescale 1ns/1ps

module psgWaveChannel #(
	parameter int ChanIndex = 0
) (
	input logic clk,
	input logic rst,
	input logic regWe,
	input logic [psgCfgPkg::ChanIdxWidth-1:0] regChan,
	input psgRegPkg::regFieldE regField,
	input logic [psgRegPkg::RegDataWidth-1:0] regData,
	input logic frameStart,
	psgFetchIf.chan fetch,
	output psgCfgPkg::sampleT sample,
	output psgCfgPkg::volT volume,
	output logic done
);

	localparam logic [psgCfgPkg::ChanIdxWidth-1:0] ChanId =
		ChanIndex[psgCfgPkg::ChanIdxWidth-1:0];

	psgRegPkg::chanRegsT regs;
	psgCfgPkg::phaseT phase;
	psgCfgPkg::sampleT sampleReg;
	logic [psgRegPkg::LenWidth-1:0] waveIdx;

	// upper phase byte, folded to the wave length
	assign waveIdx = phase[psgCfgPkg::PhaseWidth-1 -: psgRegPkg::LenWidth] & regs.lenMask;

	// ========================================
	// registers, phase and fetch control
	// ========================================

	always_ff @(posedge clk) begin
		if (rst) begin
			regs <= '0;
			phase <= '0;
			fetch.req <= 1'b0;
			done <= 1'b0;
		end else begin
			if (regWe && regChan == ChanId) begin
				case (regField)
					psgRegPkg::fieldIncr: regs.incr <= regData;
					psgRegPkg::fieldBase: begin
						regs.base <= regData[psgCfgPkg::AddrWidth-1:0];
						// new wave starts from its first entry
						phase <= '0;
					end
					psgRegPkg::fieldLen: regs.lenMask <= regData[psgRegPkg::LenWidth-1:0];
					psgRegPkg::fieldCtrl: begin
						regs.volume <= regData[psgCfgPkg::VolWidth-1:0];
						regs.enable <= regData[psgRegPkg::EnableBit];
					end
				endcase
			end
			if (frameStart) begin
				if (regs.enable) begin
					fetch.req <= 1'b1;
					phase <= phase + regs.incr;
					done <= 1'b0;
				end else begin
					done <= 1'b1;
				end
			end else if (fetch.ack) begin
				fetch.req <= 1'b0;
				done <= 1'b1;
			end
		end
	end

	// address is taken from the phase before it advances
	always_ff @(posedge clk) begin
		if (frameStart) begin
			fetch.addr <= regs.base + psgCfgPkg::memAddrT'(waveIdx);
			if (!regs.enable)
				sampleReg <= '0;
		end
		if (fetch.ack)
			sampleReg <= fetch.data;
	end

	assign sample = sampleReg;
	assign volume = regs.volume;

endmodule

//--- hdl/psgWaveMem.sv
`timescale 1ns/1ps

module psgWaveMem #(
	parameter int NumChannels = 4
) (
	input logic clk,
	input logic rst,
	input logic memWe,
	input psgCfgPkg::memAddrT memAddr,
	input psgCfgPkg::sampleT memData,
	psgFetchIf.mem fetch [NumChannels],
	input logic [psgCfgPkg::ChanIdxWidth-1:0] owner,
	input logic busy,
	output logic busAck
);

	psgCfgPkg::sampleT ram [2**psgCfgPkg::AddrWidth];
	psgCfgPkg::memAddrT chanAddr [psgCfgPkg::MaxChannels];
	psgCfgPkg::sampleT rdData;
	logic readStage;
	logic ackReg;

	for (genvar i = 0; i < psgCfgPkg::MaxChannels; i++) begin : genPort
		if (i < NumChannels) begin : genUsed
			assign chanAddr[i] = fetch[i].addr;
			assign fetch[i].data = rdData;
			assign fetch[i].ack = ackReg && (owner == i);
		end else begin : genIdle
			assign chanAddr[i] = '0;
		end
	end

	always_ff @(posedge clk) begin
		if (memWe)
			ram[memAddr] <= memData;
	end

	// one read per grant, ack lands two cycles after grant rises
	always_ff @(posedge clk) begin
		if (busy && !readStage && !ackReg)
			rdData <= ram[chanAddr[owner]];
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			readStage <= 1'b0;
			ackReg <= 1'b0;
		end else begin
			readStage <= busy && !readStage && !ackReg;
			ackReg <= readStage;
		end
	end

	assign busAck = ackReg;

endmodule

//--- hdl/psgWaveTop.sv
`timescale 1ns/1ps

module psgWaveTop #(
	parameter int NumChannels = 4
) (
	input logic clk,
	input logic rst,
	input logic tickValid,
	output logic tickReady,
	output logic outValid,
	input logic outReady,
	output psgCfgPkg::outSampleT outSample,
	input logic regWe,
	input logic [psgCfgPkg::ChanIdxWidth-1:0] regChan,
	input psgRegPkg::regFieldE regField,
	input logic [psgRegPkg::RegDataWidth-1:0] regData,
	input logic memWe,
	input psgCfgPkg::memAddrT memAddr,
	input psgCfgPkg::sampleT memData
);

	logic frameStart;
	logic [NumChannels-1:0] done;
	psgCfgPkg::sampleT sample [NumChannels];
	psgCfgPkg::volT volume [NumChannels];
	logic [psgCfgPkg::ChanIdxWidth-1:0] owner;
	logic busy;
	logic busAck;

	psgFetchIf fetch [NumChannels] ();

	// ========================================
	// wave table channels
	// ========================================

	for (genvar i = 0; i < NumChannels; i++) begin : genChan
		psgWaveChannel #(.ChanIndex(i)) chan (
			.clk(clk),
			.rst(rst),
			.regWe(regWe),
			.regChan(regChan),
			.regField(regField),
			.regData(regData),
			.frameStart(frameStart),
			.fetch(fetch[i]),
			.sample(sample[i]),
			.volume(volume[i]),
			.done(done[i])
		);
	end

	psgBusArb #(.NumChannels(NumChannels)) arb (
		.clk(clk),
		.rst(rst),
		.fetch(fetch),
		.busAck(busAck),
		.owner(owner),
		.busy(busy)
	);

	psgWaveMem #(.NumChannels(NumChannels)) mem (
		.clk(clk),
		.rst(rst),
		.memWe(memWe),
		.memAddr(memAddr),
		.memData(memData),
		.fetch(fetch),
		.owner(owner),
		.busy(busy),
		.busAck(busAck)
	);

	psgFrameMixer #(.NumChannels(NumChannels)) mixer (
		.clk(clk),
		.rst(rst),
		.tickValid(tickValid),
		.tickReady(tickReady),
		.frameStart(frameStart),
		.done(done),
		.sample(sample),
		.volume(volume),
		.outValid(outValid),
		.outReady(outReady),
		.outSample(outSample)
	);

endmodule

//--- psgWave.f
hdl/psgCfgPkg.sv
hdl/psgRegPkg.sv
hdl/psgFetchIf.sv
hdl/psgBusArb.sv
hdl/psgWaveChannel.sv
hdl/psgWaveMem.sv
hdl/psgFrameMixer.sv
hdl/psgWaveTop.sv
tests/psgClkGen.sv
tests/psgWaveTb.sv

//--- run.sh
#!/bin/sh
# build the wave fetch testbench with Verilator and run it from the project root
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module psgWaveTb \
	--Mdir obj_dir -o psgWaveSim -f psgWave.f

./obj_dir/psgWaveSim > sim.log 2>&1
cat sim.log

if grep -qx "all tests passed" sim.log; then
	echo "simulation run ok"
else
	echo "simulation run reported failure"
	exit 1
fi

//--- tests/psgClkGen.sv
`timescale 1ns/1ps

module psgClkGen #(
	parameter int HalfPeriod = 20,
	parameter int ResetCycles = 8
) (
	output logic clk,
	output logic rst
);

	initial begin
		clk = 1'b0;
		forever #(HalfPeriod) clk = ~clk;
	end

	// release lands just after an edge, like every other input
	initial begin
		rst = 1'b1;
		repeat (ResetCycles) @(posedge clk);
		#2 rst = 1'b0;
	end

endmodule

//--- tests/psgWaveTb.sv
`timescale 1ns/1ps

module psgWaveTb;

	localparam int ClkPeriod = 40;
	localparam int CyclesPerLine = 200;

	logic clk;
	logic rst;
	logic tickValid;
	logic tickReady;
	logic outValid;
	logic outReady;
	psgCfgPkg::outSampleT outSample;
	logic regWe;
	logic [psgCfgPkg::ChanIdxWidth-1:0] regChan;
	psgRegPkg::regFieldE regField;
	logic [psgRegPkg::RegDataWidth-1:0] regData;
	logic memWe;
	psgCfgPkg::memAddrT memAddr;
	psgCfgPkg::sampleT memData;

	string lines [$];
	int errors = 0;
	int lineCount = 0;

	psgClkGen #(.HalfPeriod(ClkPeriod / 2), .ResetCycles(8)) clkGen (.clk(clk), .rst(rst));

	psgWaveTop #(.NumChannels(4)) uut (
		.clk(clk),
		.rst(rst),
		.tickValid(tickValid),
		.tickReady(tickReady),
		.outValid(outValid),
		.outReady(outReady),
		.outSample(outSample),
		.regWe(regWe),
		.regChan(regChan),
		.regField(regField),
		.regData(regData),
		.memWe(memWe),
		.memAddr(memAddr),
		.memData(memData)
	);

	// ========================================
	// helpers
	// ========================================

	task automatic showMismatch(string name, logic [15:0] expected, logic [15:0] actual);
		$display("Error at %0d ns: %s expected %h, got %h", $time, name, expected, actual);
		errors++;
	endtask

	// all driving and sampling happens 2 ns after the rising edge
	task automatic nextCycle();
		@(posedge clk);
		#2;
	endtask

	task automatic waitTickReady();
		while (tickReady !== 1'b1)
			nextCycle();
	endtask

	task automatic waitOutput();
		while (outValid !== 1'b1)
			nextCycle();
	endtask

	task automatic writeMem(int addr, int data);
		waitTickReady();
		memWe = 1'b1;
		memAddr = addr[psgCfgPkg::AddrWidth-1:0];
		memData = data[psgCfgPkg::SampleWidth-1:0];
		nextCycle();
		memWe = 1'b0;
	endtask

	task automatic writeReg(int chan, int field, int data);
		waitTickReady();
		regWe = 1'b1;
		regChan = chan[psgCfgPkg::ChanIdxWidth-1:0];
		regField = psgRegPkg::regFieldE'(field[1:0]);
		regData = data[psgRegPkg::RegDataWidth-1:0];
		nextCycle();
		regWe = 1'b0;
	endtask

	task automatic startTick();
		tickValid = 1'b1;
		nextCycle();
		tickValid = 1'b0;
	endtask

	task automatic runTick(logic [15:0] expected);
		waitTickReady();
		startTick();
		waitOutput();
		if (outSample !== expected)
			showMismatch("outSample", expected, outSample);
		// outReady is high, so the sample leaves at this edge
		nextCycle();
	endtask

	task automatic runStalledTick(int hold, logic [15:0] expected);
		int stall;
		psgCfgPkg::outSampleT held;
		stall = hold + int'($urandom % 4);
		waitTickReady();
		outReady = 1'b0;
		startTick();
		waitOutput();
		held = outSample;
		if (outSample !== expected)
			showMismatch("outSample", expected, outSample);
		// a second tick is offered and must not be taken while the output waits
		tickValid = 1'b1;
		repeat (stall) begin
			nextCycle();
			if (outValid !== 1'b1)
				showMismatch("outValid", 16'd1, {15'd0, outValid});
			if (outSample !== held)
				showMismatch("outSample", held, outSample);
			if (tickReady !== 1'b0)
				showMismatch("tickReady", 16'd0, {15'd0, tickReady});
		end
		tickValid = 1'b0;
		outReady = 1'b1;
		nextCycle();
		if (outValid !== 1'b0)
			showMismatch("outValid", 16'd0, {15'd0, outValid});
		if (tickReady !== 1'b1)
			showMismatch("tickReady", 16'd1, {15'd0, tickReady});
	endtask

	task automatic loadVectors();
		int fd;
		string line;
		fd = $fopen("tests/psgWaveVectors.txt", "r");
		if (fd == 0) begin
			$display("could not open the vector file tests/psgWaveVectors.txt");
			errors++;
		end else begin
			while (!$feof(fd)) begin
				line = "";
				void'($fgets(line, fd));
				// comments and blank lines carry no command
				if (line.len() > 1 && line.getc(0) != "#")
					lines.push_back(line);
			end
			$fclose(fd);
		end
		lineCount = lines.size();
	endtask

	task automatic finishRun();
		$display("vector lines run: %0d, errors: %0d", lineCount, errors);
		if (errors == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	endtask

	// ========================================
	// main sequence
	// ========================================

	initial begin
		int a;
		int b;
		int c;
		byte cmd;
		string args;
		tickValid = 1'b0;
		outReady = 1'b1;
		regWe = 1'b0;
		regChan = '0;
		regField = psgRegPkg::fieldIncr;
		regData = '0;
		memWe = 1'b0;
		memAddr = '0;
		memData = '0;
		void'($urandom(87020));
		loadVectors();
		wait (rst === 1'b1);
		wait (rst === 1'b0);
		nextCycle();
		if (tickReady !== 1'b1)
			showMismatch("tickReady", 16'd1, {15'd0, tickReady});
		if (outValid !== 1'b0)
			showMismatch("outValid", 16'd0, {15'd0, outValid});
		foreach (lines[i]) begin
			a = 0;
			b = 0;
			c = 0;
			cmd = lines[i].getc(0);
			args = lines[i].substr(1, lines[i].len() - 1);
			void'($sscanf(args, "%h %h %h", a, b, c));
			case (cmd)
				"M": writeMem(a, b);
				"R": writeReg(a, b, c);
				"T": runTick(a[15:0]);
				"B": runStalledTick(a, b[15:0]);
				default: begin
					$display("vector line %0d holds an unknown command", i + 1);
					errors++;
				end
			endcase
		end
		finishRun();
	end

	// limit grows with the number of vector lines
	initial begin
		wait (lineCount > 0);
		#(lineCount * CyclesPerLine * ClkPeriod);
		$display("watchdog expired before all vector lines were run");
		$display("tests failed");
		$finish;
	end

endmodule

//--- tests/psgWaveVectors.txt
# M addr data : sample memory write, all hex
# R chan field data : register write, field 0 incr, 1 base, 2 len, 3 ctrl
# T expect : one tick, expected 16-bit output sample
# B hold expect : tick with outReady held low for at least hold cycles
# idle frame, nothing enabled
T 0000
# channel 0 wave, entry 4 lies outside the length mask
M 000 0a
M 001 14
M 002 fb
M 003 07
M 004 63
R 0 1 000
R 0 2 03
R 0 0 0180
R 0 3 13
T 001e
T 003c
T 0015
T 001e
T fff1
# waves for channels 1 to 3, channel 3 wraps past the top address
M 100 40
M 101 80
M 200 7f
M 3ff f0
R 1 1 100
R 1 2 01
R 1 0 0100
R 1 3 1f
R 2 1 200
R 2 3 11
R 3 1 3ff
R 3 2 01
R 3 0 0100
R 3 3 12
T 0434
B 5 f94f
# restart channel 0, mute channel 1, disable channel 2
R 0 1 000
R 1 3 10
R 2 3 01
T fffe
T 0050
B 3 fff5
